//--- common/rv_decode_pkg.sv
// Decode stage types, opcode, funct and size constants, kind and format enums, control records
package rv_decode_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [5:0]  shamt_t;
    typedef logic [2:0]  mem_size_t;

    // Major opcodes of the supported RV64IM subset
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG_W  = 7'b0111011;
    localparam opcode_t OP_IMM_W  = 7'b0011011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000; // SUB and arithmetic shifts
    localparam funct7_t F7_MULDIV = 7'b0000001; // M extension

    // Access size codes as seen by the memory stage
    localparam mem_size_t SIZE_BYTE   = 3'd1;
    localparam mem_size_t SIZE_HALF   = 3'd2;
    localparam mem_size_t SIZE_WORD   = 3'd4;
    localparam mem_size_t SIZE_DOUBLE = 3'd7;

    localparam reg_idx_t REG_A0 = 5'd10; // ECALL destination

    // Kind codes keep the numbering the execute stage already relies on
    typedef enum logic [7:0] {
        KIND_ADD    = 8'd0,  KIND_SUB    = 8'd1,  KIND_XOR    = 8'd2,  KIND_OR     = 8'd3,
        KIND_AND    = 8'd4,  KIND_SLL    = 8'd5,  KIND_SRL    = 8'd6,  KIND_SRA    = 8'd7,
        KIND_SLT    = 8'd8,  KIND_SLTU   = 8'd9,  KIND_MUL    = 8'd10, KIND_MULH   = 8'd11,
        KIND_MULHSU = 8'd12, KIND_MULHU  = 8'd13, KIND_DIV    = 8'd14, KIND_DIVU   = 8'd15,
        KIND_REM    = 8'd16, KIND_REMU   = 8'd17,
        KIND_ADDI   = 8'd18, KIND_XORI   = 8'd19, KIND_ORI    = 8'd20, KIND_ANDI   = 8'd21,
        KIND_SLLI   = 8'd22, KIND_SRLI   = 8'd23, KIND_SRAI   = 8'd24, KIND_SLTI   = 8'd25,
        KIND_SLTIU  = 8'd26,
        KIND_ADDIW  = 8'd29, KIND_SLLIW  = 8'd30, KIND_SRLIW  = 8'd31, KIND_SRAIW  = 8'd32,
        KIND_ADDW   = 8'd33, KIND_SUBW   = 8'd34, KIND_SLLW   = 8'd35, KIND_SRLW   = 8'd36,
        KIND_SRAW   = 8'd37, KIND_MULW   = 8'd38, KIND_DIVW   = 8'd39, KIND_DIVUW  = 8'd40,
        KIND_REMW   = 8'd41, KIND_REMUW  = 8'd42,
        KIND_SB     = 8'd43, KIND_SH     = 8'd44, KIND_SW     = 8'd45, KIND_SD     = 8'd46,
        KIND_BEQ    = 8'd47, KIND_BNE    = 8'd48, KIND_BLT    = 8'd49, KIND_BGE    = 8'd50,
        KIND_BLTU   = 8'd51, KIND_BGEU   = 8'd52,
        KIND_JAL    = 8'd53, KIND_JALR   = 8'd54, KIND_LUI    = 8'd55, KIND_AUIPC  = 8'd56,
        KIND_ECALL  = 8'd57, KIND_EBREAK = 8'd58,
        KIND_LB     = 8'd59, KIND_LH     = 8'd60, KIND_LW     = 8'd61, KIND_LBU    = 8'd62,
        KIND_LHU    = 8'd63, KIND_LWU    = 8'd64, KIND_LD     = 8'd65,
        KIND_UNKNOWN = 8'd255
    } instr_kind_e;

    typedef enum logic [2:0] {
        FMT_NONE = 3'd0, // R and W types carry no immediate
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5,
        FMT_SYS  = 3'd6  // Zero-extended funct12
    } imm_fmt_e;

    // Classifier result, all combinational
    typedef struct packed {
        instr_kind_e kind;
        imm_fmt_e    fmt;
        logic        rd_used;
        logic        rs1_used;
        logic        rs2_used;
        logic        rd_is_a0;
        mem_size_t   mem_size;
        logic        load_signed;
        logic        mem_read;
        logic        mem_write;
    } op_class_t;

    // Registered record handed to the next stage
    typedef struct packed {
        xlen_t       pc;
        opcode_t     opcode;
        instr_kind_e kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        xlen_t       imm;
        shamt_t      shamt;
        mem_size_t   mem_size;
        logic        load_signed;
        logic        mem_read;
        logic        mem_write;
    } decode_ctrl_t;

endpackage

//--- decoder/decode_stage.sv
// Registered RV64IM decode stage built from the classifier and the immediate generator
`timescale 1ns/1ns
module decode_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        decode_enable,
    input  rv_decode_pkg::instr_word_t  instruction,
    input  rv_decode_pkg::xlen_t        pc_current,
    output logic                        decode_valid,
    output rv_decode_pkg::decode_ctrl_t ctrl_out
);
    import rv_decode_pkg::*;

    op_class_t    cls;
    xlen_t        imm;
    shamt_t       shamt;
    decode_ctrl_t ctrl_next;

    op_classify u_op_classify (
        .instruction (instruction),
        .op_class    (cls)
    );

    imm_gen u_imm_gen (
        .instruction (instruction),
        .fmt         (cls.fmt),
        .imm         (imm),
        .shamt       (shamt)
    );

    // Unused register fields are forced to x0
    always_comb begin
        ctrl_next.pc = pc_current;
        ctrl_next.opcode = instruction[6:0];
        ctrl_next.kind = cls.kind;
        if (cls.rd_is_a0)
            ctrl_next.rd = REG_A0;
        else
            ctrl_next.rd = cls.rd_used ? instruction[11:7] : '0;
        ctrl_next.rs1 = cls.rs1_used ? instruction[19:15] : '0;
        ctrl_next.rs2 = cls.rs2_used ? instruction[24:20] : '0;
        ctrl_next.imm = imm;
        ctrl_next.shamt = shamt;
        ctrl_next.mem_size = cls.mem_size;
        ctrl_next.load_signed = cls.load_signed;
        ctrl_next.mem_read = cls.mem_read;
        ctrl_next.mem_write = cls.mem_write;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_valid <= 1'b0;
            ctrl_out <= '0;
        end else begin
            decode_valid <= decode_enable; // One pulse per accepted word
            if (decode_enable)
                ctrl_out <= ctrl_next; // Holds while idle
        end
    end

    // Exactly one cycle from strobe to valid, no pulses of its own
    assert property (@(posedge clk) disable iff (reset)
        decode_valid == ($past(decode_enable) && !$past(reset)))
        else $error("decode_stage: decode_valid does not follow decode_enable by one cycle");

endmodule

//--- decoder/imm_gen.sv
// Immediate generator for the RISC-V formats and shift amount extraction
`timescale 1ns/1ns
module imm_gen (
    input  rv_decode_pkg::instr_word_t instruction,
    input  rv_decode_pkg::imm_fmt_e    fmt,
    output rv_decode_pkg::xlen_t       imm,
    output rv_decode_pkg::shamt_t      shamt
);
    import rv_decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    sign;
    logic    is_shift;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign sign = instruction[31];
    assign is_shift = (fmt == FMT_I) && (funct3[1:0] == 2'b01); // SLLI/SRLI/SRAI families

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{52{sign}}, instruction[31:20]};
            FMT_S:   imm = {{52{sign}}, instruction[31:25], instruction[11:7]};
            FMT_B:   imm = {{52{sign}}, instruction[7], instruction[30:25],
                            instruction[11:8], 1'b0};
            FMT_U:   imm = {{32{sign}}, instruction[31:12], 12'h000};
            FMT_J:   imm = {{44{sign}}, instruction[19:12], instruction[20],
                            instruction[30:21], 1'b0};
            FMT_SYS: imm = {52'd0, instruction[31:20]}; // funct12 kept unsigned
            default: imm = '0;
        endcase
    end

    // RV64 shifts use six bits, the W forms only five
    always_comb begin
        shamt = '0;
        if (is_shift && opcode == OP_IMM)
            shamt = instruction[25:20];
        else if (is_shift && opcode == OP_IMM_W)
            shamt = {1'b0, instruction[24:20]};
    end

    always_comb begin
        if (fmt == FMT_B || fmt == FMT_J)
            assert (imm[0] == 1'b0)
                else $error("imm_gen: branch or jump offset is not halfword aligned");
    end

endmodule

//--- decoder/op_classify.sv
// Instruction classifier giving kind, immediate format, register usage and memory attributes
`timescale 1ns/1ns
module op_classify (
    input  rv_decode_pkg::instr_word_t instruction,
    output rv_decode_pkg::op_class_t   op_class
);
    import rv_decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // funct3[1:0] is the access width for both loads and stores
    function automatic mem_size_t size_code(input logic [1:0] width);
        case (width)
            2'b00:   return SIZE_BYTE;
            2'b01:   return SIZE_HALF;
            2'b10:   return SIZE_WORD;
            default: return SIZE_DOUBLE;
        endcase
    endfunction

    always_comb begin
        op_class = '0;
        op_class.kind = KIND_UNKNOWN;
        case (opcode)
            OP_REG: begin
                op_class.rd_used = 1'b1;
                op_class.rs1_used = 1'b1;
                op_class.rs2_used = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   op_class.kind = KIND_ADD;
                    {F7_ALT, 3'b000}:    op_class.kind = KIND_SUB;
                    {F7_BASE, 3'b100}:   op_class.kind = KIND_XOR;
                    {F7_BASE, 3'b110}:   op_class.kind = KIND_OR;
                    {F7_BASE, 3'b111}:   op_class.kind = KIND_AND;
                    {F7_BASE, 3'b001}:   op_class.kind = KIND_SLL;
                    {F7_BASE, 3'b101}:   op_class.kind = KIND_SRL;
                    {F7_ALT, 3'b101}:    op_class.kind = KIND_SRA;
                    {F7_BASE, 3'b010}:   op_class.kind = KIND_SLT;
                    {F7_BASE, 3'b011}:   op_class.kind = KIND_SLTU;
                    {F7_MULDIV, 3'b000}: op_class.kind = KIND_MUL;
                    {F7_MULDIV, 3'b001}: op_class.kind = KIND_MULH;
                    {F7_MULDIV, 3'b010}: op_class.kind = KIND_MULHSU;
                    {F7_MULDIV, 3'b011}: op_class.kind = KIND_MULHU;
                    {F7_MULDIV, 3'b100}: op_class.kind = KIND_DIV;
                    {F7_MULDIV, 3'b101}: op_class.kind = KIND_DIVU;
                    {F7_MULDIV, 3'b110}: op_class.kind = KIND_REM;
                    {F7_MULDIV, 3'b111}: op_class.kind = KIND_REMU;
                    default:             op_class.kind = KIND_UNKNOWN;
                endcase
            end
            OP_REG_W: begin
                op_class.rd_used = 1'b1;
                op_class.rs1_used = 1'b1;
                op_class.rs2_used = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   op_class.kind = KIND_ADDW;
                    {F7_ALT, 3'b000}:    op_class.kind = KIND_SUBW;
                    {F7_BASE, 3'b001}:   op_class.kind = KIND_SLLW;
                    {F7_BASE, 3'b101}:   op_class.kind = KIND_SRLW;
                    {F7_ALT, 3'b101}:    op_class.kind = KIND_SRAW;
                    {F7_MULDIV, 3'b000}: op_class.kind = KIND_MULW;
                    {F7_MULDIV, 3'b100}: op_class.kind = KIND_DIVW;
                    {F7_MULDIV, 3'b101}: op_class.kind = KIND_DIVUW;
                    {F7_MULDIV, 3'b110}: op_class.kind = KIND_REMW;
                    {F7_MULDIV, 3'b111}: op_class.kind = KIND_REMUW;
                    default:             op_class.kind = KIND_UNKNOWN;
                endcase
            end
            OP_IMM: begin
                op_class.fmt = FMT_I;
                op_class.rd_used = 1'b1;
                op_class.rs1_used = 1'b1;
                case (funct3)
                    3'b000: op_class.kind = KIND_ADDI;
                    3'b100: op_class.kind = KIND_XORI;
                    3'b110: op_class.kind = KIND_ORI;
                    3'b111: op_class.kind = KIND_ANDI;
                    3'b010: op_class.kind = KIND_SLTI;
                    3'b011: op_class.kind = KIND_SLTIU;
                    3'b001: begin // 6-bit shamt leaves bits 31:26 for the variant
                        if (instruction[31:26] == F7_BASE[6:1])
                            op_class.kind = KIND_SLLI;
                    end
                    default: begin
                        if (instruction[31:26] == F7_BASE[6:1])
                            op_class.kind = KIND_SRLI;
                        else if (instruction[31:26] == F7_ALT[6:1])
                            op_class.kind = KIND_SRAI;
                    end
                endcase
            end
            OP_IMM_W: begin
                op_class.fmt = FMT_I;
                op_class.rd_used = 1'b1;
                op_class.rs1_used = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b001}: op_class.kind = KIND_SLLIW;
                    {F7_BASE, 3'b101}: op_class.kind = KIND_SRLIW;
                    {F7_ALT, 3'b101}:  op_class.kind = KIND_SRAIW;
                    default: begin
                        if (funct3 == 3'b000)
                            op_class.kind = KIND_ADDIW; // funct7 is immediate here
                    end
                endcase
            end
            OP_LOAD: begin
                op_class.fmt = FMT_I;
                op_class.rd_used = 1'b1;
                op_class.rs1_used = 1'b1;
                op_class.mem_read = 1'b1;
                op_class.mem_size = size_code(funct3[1:0]);
                op_class.load_signed = ~funct3[2] & (funct3[1:0] != 2'b11); // LB LH LW
                case (funct3)
                    3'b000:  op_class.kind = KIND_LB;
                    3'b001:  op_class.kind = KIND_LH;
                    3'b010:  op_class.kind = KIND_LW;
                    3'b011:  op_class.kind = KIND_LD;
                    3'b100:  op_class.kind = KIND_LBU;
                    3'b101:  op_class.kind = KIND_LHU;
                    3'b110:  op_class.kind = KIND_LWU;
                    default: op_class.kind = KIND_UNKNOWN;
                endcase
            end
            OP_STORE: begin
                op_class.fmt = FMT_S;
                op_class.rs1_used = 1'b1;
                op_class.rs2_used = 1'b1;
                op_class.mem_write = 1'b1;
                op_class.mem_size = size_code(funct3[1:0]);
                case (funct3)
                    3'b000:  op_class.kind = KIND_SB;
                    3'b001:  op_class.kind = KIND_SH;
                    3'b010:  op_class.kind = KIND_SW;
                    3'b011:  op_class.kind = KIND_SD;
                    default: op_class.kind = KIND_UNKNOWN;
                endcase
            end
            OP_BRANCH: begin
                op_class.fmt = FMT_B;
                op_class.rs1_used = 1'b1;
                op_class.rs2_used = 1'b1;
                case (funct3)
                    3'b000:  op_class.kind = KIND_BEQ;
                    3'b001:  op_class.kind = KIND_BNE;
                    3'b100:  op_class.kind = KIND_BLT;
                    3'b101:  op_class.kind = KIND_BGE;
                    3'b110:  op_class.kind = KIND_BLTU;
                    3'b111:  op_class.kind = KIND_BGEU;
                    default: op_class.kind = KIND_UNKNOWN;
                endcase
            end
            OP_JAL: begin
                op_class.fmt = FMT_J;
                op_class.rd_used = 1'b1;
                op_class.kind = KIND_JAL;
            end
            OP_JALR: begin
                op_class.fmt = FMT_I;
                op_class.rd_used = 1'b1;
                op_class.rs1_used = 1'b1;
                if (funct3 == 3'b000)
                    op_class.kind = KIND_JALR;
            end
            OP_LUI, OP_AUIPC: begin
                op_class.fmt = FMT_U;
                op_class.rd_used = 1'b1;
                op_class.kind = (opcode == OP_LUI) ? KIND_LUI : KIND_AUIPC;
            end
            OP_SYSTEM: begin
                op_class.fmt = FMT_SYS;
                if (funct3 == 3'b000 && instruction[31:20] == 12'h000) begin
                    op_class.kind = KIND_ECALL;
                    op_class.rd_is_a0 = 1'b1; // Result lands in a0
                end else if (funct3 == 3'b000 && instruction[31:20] == 12'h001) begin
                    op_class.kind = KIND_EBREAK;
                end
            end
            default: op_class.kind = KIND_UNKNOWN;
        endcase

        // Unknown words carry no format, registers or memory traffic
        if (op_class.kind == KIND_UNKNOWN) begin
            op_class = '0;
            op_class.kind = KIND_UNKNOWN;
        end
    end

    always_comb begin
        assert (!(op_class.mem_read && op_class.mem_write))
            else $error("op_classify: load and store flagged on the same word");
    end

endmodule

//--- project.f
common/rv_decode_pkg.sv
decoder/op_classify.sv
decoder/imm_gen.sv
decoder/decode_stage.sv
tests/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_stage -f project.f -o sim_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- tests/tb_decode_stage.sv
// Testbench for the decode stage with LFSR stimulus, reference decoder and compare tasks
`timescale 1ns/1ns
module tb_decode_stage;
    import rv_decode_pkg::*;

    logic         clk = 1'b0;
    logic         reset;
    logic         decode_enable;
    instr_word_t  instruction;
    xlen_t        pc_current;
    logic         decode_valid;
    decode_ctrl_t ctrl_out;

    logic [15:0]  lfsr;
    xlen_t        pc_next;
    int           cycle = 0;
    decode_ctrl_t exp_q[$];
    instr_kind_e  kind_q[$];
    string        name_q[$];
    int           due_q[$];
    decode_ctrl_t last_exp = '0; // Record the output must hold between pulses

    // Kind tables indexed by funct3
    instr_kind_e base_ops [0:7] = '{KIND_ADD, KIND_SLL, KIND_SLT, KIND_SLTU,
                                    KIND_XOR, KIND_SRL, KIND_OR, KIND_AND};
    instr_kind_e imm_ops [0:7] = '{KIND_ADDI, KIND_SLLI, KIND_SLTI, KIND_SLTIU,
                                   KIND_XORI, KIND_SRLI, KIND_ORI, KIND_ANDI};
    instr_kind_e load_ops [0:7] = '{KIND_LB, KIND_LH, KIND_LW, KIND_LD,
                                    KIND_LBU, KIND_LHU, KIND_LWU, KIND_UNKNOWN};
    instr_kind_e branch_ops [0:7] = '{KIND_BEQ, KIND_BNE, KIND_UNKNOWN, KIND_UNKNOWN,
                                      KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU};
    mem_size_t size_codes [0:3] = '{SIZE_BYTE, SIZE_HALF, SIZE_WORD, SIZE_DOUBLE};
    opcode_t op_list [0:11] = '{OP_REG, OP_IMM, OP_REG_W, OP_IMM_W, OP_LOAD, OP_STORE,
                                OP_BRANCH, OP_JAL, OP_JALR, OP_LUI, OP_AUIPC, OP_SYSTEM};

    decode_stage u_decode_stage (
        .clk           (clk),
        .reset         (reset),
        .decode_enable (decode_enable),
        .instruction   (instruction),
        .pc_current    (pc_current),
        .decode_valid  (decode_valid),
        .ctrl_out      (ctrl_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Sign-extends the low bits of v to 64 bits
    function automatic xlen_t sext(input logic [31:0] v, input int bits);
        logic signed [63:0] t;
        t = $signed({32'd0, v});
        t = t <<< (64 - bits);
        t = t >>> (64 - bits);
        return t;
    endfunction

    function automatic decode_ctrl_t ref_decode(input instr_word_t w, input xlen_t pc);
        decode_ctrl_t r;
        funct3_t      f3;
        funct7_t      f7;
        imm_fmt_e     fmt;
        logic [2:0]   used; // rd, rs1, rs2
        logic         ecall;
        r = '0;
        f3 = w[14:12];
        f7 = w[31:25];
        fmt = FMT_NONE;
        used = 3'b000;
        ecall = 1'b0;
        r.kind = KIND_UNKNOWN;
        case (w[6:0])
            OP_REG: begin
                used = 3'b111;
                if (f7 == F7_MULDIV)
                    r.kind = instr_kind_e'(8'd10 + {5'd0, f3});
                else if (f7 == F7_BASE)
                    r.kind = base_ops[f3];
                else if (f7 == F7_ALT && f3 == 3'd0)
                    r.kind = KIND_SUB;
                else if (f7 == F7_ALT && f3 == 3'd5)
                    r.kind = KIND_SRA;
            end
            OP_REG_W: begin
                used = 3'b111;
                if (f7 == F7_MULDIV && f3 == 3'd0)
                    r.kind = KIND_MULW;
                else if (f7 == F7_MULDIV && f3[2])
                    r.kind = instr_kind_e'(8'd35 + {5'd0, f3}); // DIVW through REMUW
                else if (f7 == F7_BASE || f7 == F7_ALT) begin
                    case ({f7[5], f3})
                        4'b0000: r.kind = KIND_ADDW;
                        4'b0001: r.kind = KIND_SLLW;
                        4'b0101: r.kind = KIND_SRLW;
                        4'b1000: r.kind = KIND_SUBW;
                        4'b1101: r.kind = KIND_SRAW;
                        default: r.kind = KIND_UNKNOWN;
                    endcase
                end
            end
            OP_IMM: begin
                used = 3'b110;
                fmt = FMT_I;
                r.kind = imm_ops[f3];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    r.shamt = w[25:20];
                    if (f3 == 3'd5 && w[31:26] == 6'b010000)
                        r.kind = KIND_SRAI;
                    else if (w[31:26] != 6'b000000)
                        r.kind = KIND_UNKNOWN;
                end
            end
            OP_IMM_W: begin
                used = 3'b110;
                fmt = FMT_I;
                if (f3 == 3'd0)
                    r.kind = KIND_ADDIW;
                else if (f3 == 3'd1 && f7 == F7_BASE)
                    r.kind = KIND_SLLIW;
                else if (f3 == 3'd5 && f7 == F7_BASE)
                    r.kind = KIND_SRLIW;
                else if (f3 == 3'd5 && f7 == F7_ALT)
                    r.kind = KIND_SRAIW;
                if (f3 == 3'd1 || f3 == 3'd5)
                    r.shamt = {1'b0, w[24:20]};
            end
            OP_LOAD: begin
                used = 3'b110;
                fmt = FMT_I;
                r.kind = load_ops[f3];
                r.mem_read = 1'b1;
                r.mem_size = size_codes[f3[1:0]];
                r.load_signed = (f3 <= 3'd2);
            end
            OP_STORE: begin
                used = 3'b011;
                fmt = FMT_S;
                if (!f3[2])
                    r.kind = instr_kind_e'(8'd43 + {5'd0, f3});
                r.mem_write = 1'b1;
                r.mem_size = size_codes[f3[1:0]];
            end
            OP_BRANCH: begin
                used = 3'b011;
                fmt = FMT_B;
                r.kind = branch_ops[f3];
            end
            OP_JAL: begin
                used = 3'b100;
                fmt = FMT_J;
                r.kind = KIND_JAL;
            end
            OP_JALR: begin
                used = 3'b110;
                fmt = FMT_I;
                if (f3 == 3'd0)
                    r.kind = KIND_JALR;
            end
            OP_LUI, OP_AUIPC: begin
                used = 3'b100;
                fmt = FMT_U;
                r.kind = (w[6:0] == OP_LUI) ? KIND_LUI : KIND_AUIPC;
            end
            OP_SYSTEM: begin
                fmt = FMT_SYS;
                if (f3 == 3'd0 && w[31:20] == 12'd0) begin
                    r.kind = KIND_ECALL;
                    ecall = 1'b1;
                end else if (f3 == 3'd0 && w[31:20] == 12'd1)
                    r.kind = KIND_EBREAK;
            end
            default: r.kind = KIND_UNKNOWN;
        endcase
        if (r.kind == KIND_UNKNOWN) begin
            r = '0; // Only pc, opcode and kind survive
            r.kind = KIND_UNKNOWN;
        end else begin
            r.rd = ecall ? REG_A0 : (used[2] ? w[11:7] : 5'd0);
            r.rs1 = used[1] ? w[19:15] : 5'd0;
            r.rs2 = used[0] ? w[24:20] : 5'd0;
            case (fmt)
                FMT_I:   r.imm = sext({20'd0, w[31:20]}, 12);
                FMT_S:   r.imm = sext({20'd0, w[31:25], w[11:7]}, 12);
                FMT_B:   r.imm = sext({19'd0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                FMT_U:   r.imm = sext({w[31:12], 12'd0}, 32);
                FMT_J:   r.imm = sext({11'd0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                FMT_SYS: r.imm = {52'd0, w[31:20]};
                default: r.imm = '0;
            endcase
        end
        r.pc = pc;
        r.opcode = w[6:0];
        return r;
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "decode stage testbench stopped on an error");
    endtask

    task automatic check_ctrl(input string name, input decode_ctrl_t exp, input decode_ctrl_t act);
        if (act !== exp)
            stop_with_error($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_kind(input string name, input instr_kind_e exp, input instr_kind_e act);
        if (act !== exp)
            stop_with_error($sformatf("mismatch %s kind: expected %0d actual %0d",
                                      name, exp, act));
    endtask

    task automatic check_idle_outputs(input string name);
        if (decode_valid !== 1'b0)
            stop_with_error($sformatf("%s: decode_valid is high before any word was sent", name));
        else
            check_ctrl(name, '0, ctrl_out);
    endtask

    // Sampled mid-cycle, away from the edge that updates the outputs
    always @(negedge clk) begin
        if (!reset) begin
            if (decode_valid && due_q.size() == 0)
                stop_with_error("decode_valid pulsed with no word outstanding");
            else if (decode_valid && due_q[0] != cycle)
                stop_with_error($sformatf("%s: decode_valid came in the wrong cycle", name_q[0]));
            else if (decode_valid) begin
                check_kind(name_q[0], kind_q[0], ctrl_out.kind);
                check_ctrl(name_q[0], exp_q[0], ctrl_out);
                last_exp = exp_q.pop_front();
                void'(kind_q.pop_front());
                void'(name_q.pop_front());
                void'(due_q.pop_front());
            end else if (due_q.size() != 0 && due_q[0] <= cycle)
                stop_with_error($sformatf("%s: decode_valid never came", name_q[0]));
            else
                check_ctrl("idle_hold", last_exp, ctrl_out); // Last record stays put
        end
    end

    task automatic send_word(input string name, input instr_word_t w, input instr_kind_e kind);
        @(posedge clk);
        #1;
        decode_enable = 1'b1;
        instruction = w;
        pc_current = pc_next;
        exp_q.push_back(ref_decode(w, pc_next));
        kind_q.push_back(kind);
        name_q.push_back(name);
        due_q.push_back(cycle + 1); // Sampled at the next edge
        pc_next = pc_next + 64'd4;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            decode_enable = 1'b0;
            instruction = ~instruction; // Must not disturb the held record
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (due_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (due_q.size() != 0)
            stop_with_error("timed out waiting for decode_valid");
    endtask

    task automatic make_random_word(output instr_word_t w);
        logic [31:0] bits;
        opcode_t     op;
        funct7_t     f7;
        take_bits(4, bits);
        op = op_list[bits[3:0] % 12];
        if (bits[3:2] == 2'b11) begin // Occasional opcode outside the list
            take_bits(7, bits);
            op = bits[6:0];
        end
        take_bits(2, bits);
        case (bits[1:0])
            2'd0: f7 = F7_BASE;
            2'd1: f7 = F7_ALT;
            2'd2: f7 = F7_MULDIV;
            default: begin
                take_bits(7, bits);
                f7 = bits[6:0];
            end
        endcase
        take_bits(18, bits);
        w = {f7, bits[17:0], op};
    endtask

    function automatic instr_word_t r_word(input funct7_t f7, input funct3_t f3, input opcode_t op);
        return {f7, 5'd3, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic instr_word_t i_word(input logic [11:0] imm, input funct3_t f3,
                                           input opcode_t op);
        return {imm, 5'd5, f3, 5'd7, op};
    endfunction

    initial begin
        logic [31:0]  bits;
        instr_word_t  w;
        decode_ctrl_t exp_r;
        reset = 1'b1;
        decode_enable = 1'b0;
        instruction = '0;
        pc_current = '0;
        lfsr = 16'd91;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_idle_outputs("reset");
        end
        reset = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_idle_outputs("after_reset");
        end
        take_bits(30, bits);
        pc_next = {32'd0, bits[29:0], 2'b00};

        send_word("add", r_word(F7_BASE, 3'd0, OP_REG), KIND_ADD);
        send_word("sub", r_word(F7_ALT, 3'd0, OP_REG), KIND_SUB);
        send_word("sra", r_word(F7_ALT, 3'd5, OP_REG), KIND_SRA);
        send_word("mulhsu", r_word(F7_MULDIV, 3'd2, OP_REG), KIND_MULHSU);
        send_word("remu", r_word(F7_MULDIV, 3'd7, OP_REG), KIND_REMU);
        send_word("reg_bad_f7", r_word(7'b0000010, 3'd0, OP_REG), KIND_UNKNOWN);
        send_word("subw", r_word(F7_ALT, 3'd0, OP_REG_W), KIND_SUBW);
        send_word("mulw", r_word(F7_MULDIV, 3'd0, OP_REG_W), KIND_MULW);
        send_word("mulhw_bad", r_word(F7_MULDIV, 3'd1, OP_REG_W), KIND_UNKNOWN);
        send_word("srai", i_word({6'b010000, 6'd45}, 3'd5, OP_IMM), KIND_SRAI);
        send_word("slli_bad", i_word({6'b000001, 6'd3}, 3'd1, OP_IMM), KIND_UNKNOWN);
        send_word("sraiw", i_word({7'b0100000, 5'd31}, 3'd5, OP_IMM_W), KIND_SRAIW);
        send_word("addiw_neg", i_word(12'hFFF, 3'd0, OP_IMM_W), KIND_ADDIW);
        send_word("lb_neg", i_word(12'h800, 3'd0, OP_LOAD), KIND_LB);
        send_word("lwu", i_word(12'h010, 3'd6, OP_LOAD), KIND_LWU);
        send_word("ld", i_word(12'h008, 3'd3, OP_LOAD), KIND_LD);
        send_word("load_bad", i_word(12'h000, 3'd7, OP_LOAD), KIND_UNKNOWN);
        send_word("sh_neg", {7'h7F, 5'd4, 5'd6, 3'd1, 5'h1F, OP_STORE}, KIND_SH);
        send_word("sd", {7'h01, 5'd4, 5'd6, 3'd3, 5'h08, OP_STORE}, KIND_SD);
        send_word("beq_neg", {7'h40, 5'd2, 5'd1, 3'd0, 5'h01, OP_BRANCH}, KIND_BEQ);
        send_word("bgeu", {7'h3F, 5'd2, 5'd1, 3'd7, 5'h1E, OP_BRANCH}, KIND_BGEU);
        send_word("jal_neg", {1'b1, 10'h3FF, 1'b1, 8'hFF, 5'd1, OP_JAL}, KIND_JAL);
        send_word("jalr_neg", i_word(12'hF00, 3'd0, OP_JALR), KIND_JALR);
        send_word("lui_neg", {20'hABCDE, 5'd3, OP_LUI}, KIND_LUI);
        send_word("auipc", {20'h12345, 5'd4, OP_AUIPC}, KIND_AUIPC);
        send_word("ecall", 32'h0000_0073, KIND_ECALL);
        send_word("ebreak", 32'h0010_0073, KIND_EBREAK);
        send_word("zero_word", 32'h0000_0000, KIND_UNKNOWN);
        idle_cycles(1);
        wait_drain();

        // Back-to-back stream
        for (int i = 0; i < 200; i++) begin
            make_random_word(w);
            exp_r = ref_decode(w, '0);
            send_word($sformatf("random_%0d", i), w, exp_r.kind);
        end
        idle_cycles(1);
        wait_drain();

        // Random idle gaps between strobes
        for (int i = 0; i < 40; i++) begin
            make_random_word(w);
            exp_r = ref_decode(w, '0);
            send_word($sformatf("gap_%0d", i), w, exp_r.kind);
            take_bits(2, bits);
            idle_cycles(int'(bits[1:0]));
        end
        idle_cycles(1);
        wait_drain();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
